//--- hdl/fir_pkg.sv
// Shared widths, limits and packed types for the streaming FIR core
// Every core module imports this package
`default_nettype none

package fir_pkg;

  //////////////////////////////////////////////////
  // Widths and limits
  //////////////////////////////////////////////////

  // Sample and coefficient width
  localparam int DATA_W = 16;
  // Tap index width, which sets the size of both stores
  localparam int TAP_ADDR_W = 5;
  localparam int MAX_TAPS = 32;
  // Width of the per-run sample count
  localparam int DATA_NUM_W = 10;
  // A full product plus TAP_ADDR_W guard bits covers MAX_TAPS products
  localparam int ACC_W = 2 * DATA_W + TAP_ADDR_W;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] sample_t;
  typedef logic signed [DATA_W-1:0] coef_t;
  typedef logic [TAP_ADDR_W-1:0] tap_addr_t;
  // One extra bit so that MAX_TAPS itself fits
  typedef logic [TAP_ADDR_W:0] tap_cnt_t;
  typedef logic [DATA_NUM_W-1:0] data_cnt_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Run configuration, held stable from start until done
  typedef struct packed {
    tap_cnt_t  tap_num;
    data_cnt_t data_num;
  } fir_cfg_t;

  // Coefficient write strobe
  typedef struct packed {
    logic      en;
    tap_addr_t addr;
    coef_t     data;
  } tap_wr_t;

  // One multiply-accumulate command, last marks the round end and final_rnd the run end
  typedef struct packed {
    logic valid;
    logic last;
    logic final_rnd;
  } mac_cmd_t;

endpackage

`default_nettype wire

//--- hdl/fir_ctrl.sv
// Run controller of the FIR core: clears the delay line, takes samples and walks the taps
// Drives the stores and the MAC command stream, and reports done
`default_nettype none

module fir_ctrl (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               ap_start,
  input  fir_pkg::fir_cfg_t       cfg,
  input  wire logic               ss_tvalid,
  output logic                    ss_tready,
  input  wire logic               stall,
  input  wire logic               out_fire,
  output logic                    ap_done,
  output fir_pkg::tap_addr_t      tap_idx,
  output logic                    shift_en,
  output logic                    clr_en,
  output fir_pkg::tap_addr_t      clr_addr,
  output fir_pkg::mac_cmd_t       mac_cmd,
  output logic                    busy
);
  import fir_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_CLEAR, ST_COMPUTE} state_e;

  state_e    state;
  tap_addr_t clr_cnt;
  tap_addr_t tap_cnt;
  data_cnt_t round_cnt;
  tap_cnt_t  tap_last;
  logic      walking;
  logic      clr_done;
  logic      tap_done;
  logic      take;
  logic      issue;

  //////////////////////////////////////////////////
  // Phase decodes
  //////////////////////////////////////////////////

  assign tap_last = cfg.tap_num - 1'b1;
  assign clr_done = {1'b0, clr_cnt} == tap_last;
  assign tap_done = {1'b0, tap_cnt} == tap_last;

  // A new sample is wanted between rounds until data_num samples have been taken
  assign ss_tready = (state == ST_COMPUTE) && !walking && (round_cnt != cfg.data_num);
  assign take = ss_tvalid && ss_tready;
  // Back-pressure holds the walk so no command is lost in the frozen MAC
  assign issue = walking && !stall;

  // round_cnt already counts the sample of the round being walked
  assign mac_cmd.valid = issue;
  assign mac_cmd.last = issue && tap_done;
  assign mac_cmd.final_rnd = issue && tap_done && (round_cnt == cfg.data_num);

  assign ap_done = (state == ST_COMPUTE) && out_fire;
  assign busy = state != ST_IDLE;
  assign clr_en = state == ST_CLEAR;
  assign clr_addr = clr_cnt;
  assign shift_en = take;
  assign tap_idx = tap_cnt;

  //////////////////////////////////////////////////
  // State machine and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      clr_cnt <= '0;
      tap_cnt <= '0;
      round_cnt <= '0;
      walking <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          clr_cnt <= '0;
          if (ap_start) begin
            state <= ST_CLEAR;
          end
        end
        ST_CLEAR: begin
          // One line entry per cycle, tap_num cycles in all
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_done) begin
            state <= ST_COMPUTE;
            round_cnt <= '0;
            tap_cnt <= '0;
            walking <= 1'b0;
          end
        end
        ST_COMPUTE: begin
          if (take) begin
            walking <= 1'b1;
            round_cnt <= round_cnt + 1'b1;
          end else if (issue) begin
            // Wrap to tap 0 on the round's last command
            tap_cnt <= tap_done ? '0 : tap_cnt + 1'b1;
            if (tap_done) begin
              walking <= 1'b0;
            end
          end
          // Leave once the final result has been handed off
          if (ap_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/tap_store.sv
// Coefficient register file of the FIR core
// Loaded through the write strobe while idle and read by the current tap index
`default_nettype none

module tap_store (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  fir_pkg::tap_wr_t   tap_wr,
  input  wire logic          busy,
  input  fir_pkg::tap_addr_t tap_idx,
  output fir_pkg::coef_t     coef
);
  import fir_pkg::*;

  coef_t taps [MAX_TAPS];

  // Writes are blocked during a run so the taps cannot change under a round
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MAX_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (tap_wr.en && !busy) begin
      taps[tap_wr.addr] <= tap_wr.data;
    end
  end

  // Combinational read so the coefficient lines up with its sample
  assign coef = taps[tap_idx];

endmodule

`default_nettype wire

//--- hdl/sample_line.sv
// Delay line holding the most recent input samples, entry 0 newest
// Shifted on each accepted sample, cleared entry by entry before a run
`default_nettype none

module sample_line (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          shift_en,
  input  fir_pkg::sample_t   ss_tdata,
  input  wire logic          clr_en,
  input  fir_pkg::tap_addr_t clr_addr,
  input  fir_pkg::tap_addr_t tap_idx,
  output fir_pkg::sample_t   sample
);
  import fir_pkg::*;

  sample_t line [MAX_TAPS];

  //////////////////////////////////////////////////
  // Shift and clear
  //////////////////////////////////////////////////

  // Clear and shift belong to different phases and never meet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MAX_TAPS; i++) begin
        line[i] <= '0;
      end
    end else if (clr_en) begin
      line[clr_addr] <= '0;
    end else if (shift_en) begin
      // Oldest sample falls off the far end
      line[0] <= ss_tdata;
      for (int i = 1; i < MAX_TAPS; i++) begin
        line[i] <= line[i-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////

  // Index k gives the sample taken k inputs before the newest one
  assign sample = line[tap_idx];

endmodule

`default_nettype wire

//--- hdl/fir_mac.sv
// Pipelined signed multiply-accumulate and output register of the FIR core
// Takes one command per cycle and presents one sum per round on the output stream
`default_nettype none

module fir_mac (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        stall,
  input  fir_pkg::mac_cmd_t mac_cmd,
  input  fir_pkg::coef_t   coef,
  input  fir_pkg::sample_t sample,
  input  wire logic        sm_tready,
  output logic             sm_tvalid,
  output fir_pkg::acc_t    sm_tdata,
  output logic             sm_tlast,
  output logic             out_fire
);
  import fir_pkg::*;

  mac_cmd_t                  cmd_q;
  mac_cmd_t                  prod_cmd_q;
  coef_t                     coef_q;
  sample_t                   sample_q;
  logic signed [2*DATA_W-1:0] prod_q;
  acc_t                      prod_ext;
  acc_t                      acc_q;
  logic                      restart_q;
  logic                      acc_last_q;
  logic                      acc_final_q;

  //////////////////////////////////////////////////
  // Control pipeline
  //////////////////////////////////////////////////

  // Every stage holds while the output waits on back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q <= '0;
      prod_cmd_q <= '0;
      restart_q <= 1'b1;
      acc_last_q <= 1'b0;
      acc_final_q <= 1'b0;
    end else if (!stall) begin
      cmd_q <= mac_cmd;
      prod_cmd_q <= cmd_q;
      // After a round's last product the next product opens a new sum
      if (prod_cmd_q.valid) begin
        restart_q <= prod_cmd_q.last;
      end
      acc_last_q <= prod_cmd_q.valid && prod_cmd_q.last;
      acc_final_q <= prod_cmd_q.final_rnd;
    end
  end

  //////////////////////////////////////////////////
  // Data pipeline
  //////////////////////////////////////////////////

  // Sign extension of the full product to accumulator width
  assign prod_ext = prod_q;

  always_ff @(posedge clk) begin
    if (!stall) begin
      coef_q <= coef;
      sample_q <= sample;
      prod_q <= coef_q * sample_q;
      if (prod_cmd_q.valid) begin
        acc_q <= restart_q ? prod_ext : acc_q + prod_ext;
      end
      // The sum is complete one edge after the last product landed
      if (acc_last_q) begin
        sm_tdata <= acc_q;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output stream
  //////////////////////////////////////////////////

  // Without stall the held result is either absent or being taken this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_tvalid <= 1'b0;
      sm_tlast <= 1'b0;
    end else if (!stall) begin
      sm_tvalid <= acc_last_q;
      if (acc_last_q) begin
        sm_tlast <= acc_final_q;
      end
    end
  end

  // Handshake of the run's final sum
  assign out_fire = sm_tvalid && sm_tready && sm_tlast;

endmodule

`default_nettype wire

//--- hdl/fir_top.sv
// Top level of the streaming FIR core
// Connects the controller, the tap store, the sample line and the MAC to the ports
`default_nettype none

module fir_top (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         ap_start,
  output logic              ap_done,
  input  fir_pkg::fir_cfg_t cfg,
  input  fir_pkg::tap_wr_t  tap_wr,
  input  wire logic         ss_tvalid,
  input  fir_pkg::sample_t  ss_tdata,
  output logic              ss_tready,
  output logic              sm_tvalid,
  output fir_pkg::acc_t     sm_tdata,
  output logic              sm_tlast,
  input  wire logic         sm_tready
);
  import fir_pkg::*;

  tap_addr_t tap_idx;
  tap_addr_t clr_addr;
  mac_cmd_t  mac_cmd;
  coef_t     coef;
  sample_t   sample;
  logic      shift_en;
  logic      clr_en;
  logic      busy;
  logic      stall;
  logic      out_fire;

  // A result held against a low ready freezes the whole datapath
  assign stall = sm_tvalid && !sm_tready;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  fir_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .ap_start  (ap_start),
    .cfg       (cfg),
    .ss_tvalid (ss_tvalid),
    .ss_tready (ss_tready),
    .stall     (stall),
    .out_fire  (out_fire),
    .ap_done   (ap_done),
    .tap_idx   (tap_idx),
    .shift_en  (shift_en),
    .clr_en    (clr_en),
    .clr_addr  (clr_addr),
    .mac_cmd   (mac_cmd),
    .busy      (busy)
  );

  //////////////////////////////////////////////////
  // Storage and arithmetic
  //////////////////////////////////////////////////

  tap_store u_taps (
    .clk     (clk),
    .rst_n   (rst_n),
    .tap_wr  (tap_wr),
    .busy    (busy),
    .tap_idx (tap_idx),
    .coef    (coef)
  );

  sample_line u_line (
    .clk      (clk),
    .rst_n    (rst_n),
    .shift_en (shift_en),
    .ss_tdata (ss_tdata),
    .clr_en   (clr_en),
    .clr_addr (clr_addr),
    .tap_idx  (tap_idx),
    .sample   (sample)
  );

  fir_mac u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .mac_cmd   (mac_cmd),
    .coef      (coef),
    .sample    (sample),
    .sm_tready (sm_tready),
    .sm_tvalid (sm_tvalid),
    .sm_tdata  (sm_tdata),
    .sm_tlast  (sm_tlast),
    .out_fire  (out_fire)
  );

endmodule

`default_nettype wire

//--- dv/fir_model.svh
// Reference model of the FIR core, included inside the testbench module
// Sums are formed in 64-bit arithmetic, far wider than the core's accumulator
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

  // Longest run whose samples the model keeps
  localparam int MAX_RUN = 64;

  // Full-precision signed product of one tap and one sample
  function automatic longint tap_product(input coef_t tap, input sample_t x);
    longint wide_tap;
    longint wide_x;
    wide_tap = longint'(tap);
    wide_x = longint'(x);
    return wide_tap * wide_x;
  endfunction

  // Output n of a run; samples from before the run's start count as zero
  function automatic longint window_sum(input coef_t taps [MAX_TAPS],
                                        input sample_t xs [MAX_RUN],
                                        input int n, input int tap_num);
    longint sum;
    sum = 0;
    for (int k = 0; k < tap_num; k++) begin
      if (n >= k) begin
        sum += tap_product(taps[k], xs[n-k]);
      end
    end
    return sum;
  endfunction

`endif

//--- dv/fir_tb.sv
// Random-stimulus testbench for the streaming FIR core
// Loads taps, streams samples under back-pressure and checks each sum against the model
`default_nettype none

module fir_tb;
  import fir_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_RUNS = 8;
  localparam int MAX_DATA = 24;
  localparam int EXTREME_DATA = 40;
  localparam int TOTAL_SAMPLES = NUM_RUNS * MAX_DATA + EXTREME_DATA;
  // Up to MAX_TAPS cycles per sample, widened fourfold for input gaps and stalls
  localparam int WATCHDOG_TIME = TOTAL_SAMPLES * MAX_TAPS * 4 * CLK_PERIOD + 20000;

  `include "fir_model.svh"

  logic      clk = 1'b0;
  logic      rst_n;
  logic      ap_start;
  logic      ap_done;
  fir_cfg_t  cfg;
  tap_wr_t   tap_wr;
  logic      ss_tvalid;
  sample_t   ss_tdata;
  logic      ss_tready;
  logic      sm_tvalid;
  acc_t      sm_tdata;
  logic      sm_tlast;
  logic      sm_tready;

  int        seed;
  string     test_name;
  coef_t     tap_model [MAX_TAPS];
  sample_t   run_samples [MAX_RUN];
  acc_t      expected_q [$];

  fir_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .ap_start  (ap_start),
    .ap_done   (ap_done),
    .cfg       (cfg),
    .tap_wr    (tap_wr),
    .ss_tvalid (ss_tvalid),
    .ss_tdata  (ss_tdata),
    .ss_tready (ss_tready),
    .sm_tvalid (sm_tvalid),
    .sm_tdata  (sm_tdata),
    .sm_tlast  (sm_tlast),
    .sm_tready (sm_tready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic int rand_between(input int lo, input int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // One coefficient write, mirrored into the model since the core is idle
  task automatic write_tap(input tap_addr_t addr, input coef_t data);
    @(negedge clk);
    tap_wr.en = 1'b1;
    tap_wr.addr = addr;
    tap_wr.data = data;
    tap_model[addr] = data;
  endtask

  task automatic load_random_taps();
    int writes;
    writes = rand_between(1, 2 * MAX_TAPS);
    for (int i = 0; i < writes; i++) begin
      write_tap(tap_addr_t'(rand_between(0, MAX_TAPS - 1)), coef_t'($random(seed)));
    end
    @(negedge clk);
    tap_wr = '0;
  endtask

  //////////////////////////////////////////////////
  // Stream drivers and output checker
  //////////////////////////////////////////////////

  // Ready only moves at rising edges, so the handshake is known right after the drive
  task automatic feed_samples(input int count);
    int   sent;
    logic fire;
    sent = 0;
    fire = 1'b0;
    while (sent < count) begin
      @(negedge clk);
      if (fire) begin
        sent++;
        ss_tvalid = 1'b0;
      end
      // Valid gaps of random length, data held until taken
      if (sent < count && !ss_tvalid && rand_between(0, 3) != 0) begin
        ss_tvalid = 1'b1;
        ss_tdata = run_samples[sent];
      end
      // Tap writes during a run must be ignored, so the model does not see them
      tap_wr.en = rand_between(0, 1) == 1;
      tap_wr.addr = tap_addr_t'(rand_between(0, MAX_TAPS - 1));
      tap_wr.data = coef_t'($random(seed));
      fire = ss_tvalid && ss_tready;
    end
    tap_wr = '0;
  endtask

  task automatic collect_outputs(input int count);
    int   got;
    logic fire;
    logic hold;
    logic held_last;
    acc_t held_data;
    acc_t want;
    got = 0;
    hold = 1'b0;
    held_last = 1'b0;
    held_data = '0;
    while (got < count) begin
      @(negedge clk);
      // Ready is high about three cycles in four
      sm_tready = rand_between(0, 3) != 0;
      #1;
      if (hold) begin
        assert (sm_tvalid && sm_tdata === held_data && sm_tlast === held_last)
          else stop_on_error($sformatf("Fail %s held output: expected %0d/%0b, actual %0d/%0b",
                                       test_name, held_data, held_last, sm_tdata, sm_tlast));
      end
      fire = sm_tvalid && sm_tready;
      assert (ap_done === (fire && got == count - 1))
        else stop_on_error($sformatf("Fail %s ap_done: expected %0b, actual %0b", test_name,
                                     fire && got == count - 1, ap_done));
      if (fire) begin
        want = expected_q.pop_front();
        assert (sm_tdata === want)
          else stop_on_error($sformatf("Fail %s output %0d: expected %0d, actual %0d",
                                       test_name, got, want, sm_tdata));
        assert (sm_tlast === (got == count - 1))
          else stop_on_error($sformatf("Fail %s tlast of output %0d: expected %0b, actual %0b",
                                       test_name, got, got == count - 1, sm_tlast));
        got++;
      end
      hold = sm_tvalid && !sm_tready;
      held_data = sm_tdata;
      held_last = sm_tlast;
    end
  endtask

  // Start a run, stream its samples and check all its sums and the done pulse
  task automatic execute_run(input int taps_used, input int samples);
    for (int n = 0; n < samples; n++) begin
      expected_q.push_back(acc_t'(window_sum(tap_model, run_samples, n, taps_used)));
    end
    @(negedge clk);
    cfg.tap_num = tap_cnt_t'(taps_used);
    cfg.data_num = data_cnt_t'(samples);
    ap_start = 1'b1;
    @(negedge clk);
    ap_start = 1'b0;
    fork
      feed_samples(samples);
      collect_outputs(samples);
    join
    @(negedge clk);
    #1;
    assert (!ap_done && !sm_tvalid && !ss_tready)
      else stop_on_error($sformatf("%s: core still active after the final handshake", test_name));
    sm_tready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed = 31;
    rst_n = 1'b0;
    ap_start = 1'b0;
    cfg = '0;
    tap_wr = '0;
    ss_tvalid = 1'b0;
    ss_tdata = '0;
    sm_tready = 1'b0;
    test_name = "reset";
    for (int i = 0; i < MAX_TAPS; i++) begin
      tap_model[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #1;
    assert (!sm_tvalid && !ss_tready && !ap_done)
      else stop_on_error($sformatf("Fail %s: expected valid/ready/done 000, actual %b%b%b",
                                   test_name, sm_tvalid, ss_tready, ap_done));

    // Random runs back to back, each starting from a freshly cleared line
    for (int run = 0; run < NUM_RUNS; run++) begin
      test_name = $sformatf("random_run_%0d", run);
      load_random_taps();
      for (int i = 0; i < MAX_DATA; i++) begin
        run_samples[i] = sample_t'($random(seed));
      end
      execute_run(rand_between(1, MAX_TAPS), rand_between(1, MAX_DATA));
    end

    // Largest product magnitudes over all taps, the accumulator's worst case
    test_name = "min_value_run";
    for (int i = 0; i < MAX_TAPS; i++) begin
      write_tap(tap_addr_t'(i), coef_t'(16'h8000));
    end
    @(negedge clk);
    tap_wr = '0;
    for (int i = 0; i < EXTREME_DATA; i++) begin
      run_samples[i] = sample_t'(16'h8000);
    end
    execute_run(MAX_TAPS, EXTREME_DATA);

    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the runs did not finish within %0d time units", WATCHDOG_TIME);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
hdl/fir_pkg.sv
hdl/fir_ctrl.sv
hdl/tap_store.sv
hdl/sample_line.sv
hdl/fir_mac.sv
hdl/fir_top.sv
dv/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the FIR testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fir_tb -f filelist.f -o Vfir_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vfir_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0
